/* design/i2c_master_pkg.sv */
package i2c_master_pkg;

    // --------------------
    // bus timing, in system clocks
    // --------------------
    localparam int QUARTER_CYCLES = 250;  // one quarter of a data bit
    localparam int HALF_CYCLES    = 500;  // one half of start or stop
    localparam int SAMPLE_CYCLE   = 124;  // read sample, mid second quarter

    // --------------------
    // widths
    // --------------------
    localparam int BYTE_BITS     = 8;
    localparam int CNT_WIDTH     = 9;     // holds HALF_CYCLES - 1
    localparam int BIT_CNT_WIDTH = $clog2(BYTE_BITS);
    localparam int QTR_WIDTH     = 2;     // quarter index within a symbol

    typedef logic [BYTE_BITS-1:0] byte_t;

    // one symbol on the bus
    // start and stop run two halves, all others four quarters
    typedef enum logic [2:0] {
        SYM_START = 3'd0,
        SYM_STOP  = 3'd1,
        SYM_WRITE = 3'd2,  // released for 1, pulled low for 0
        SYM_READ  = 3'd3,  // sda released, also the slave ack slot
        SYM_NACK  = 3'd4   // master nack, high driven in the scl high quarters
    } sym_kind_t;

endpackage

/* design/i2c_symbol_if.sv */
`timescale 1ns/1ps

interface i2c_symbol_if import i2c_master_pkg::*; ();

    // sequencer to engine
    logic      sym_go;      // one cycle, starts a symbol
    sym_kind_t sym_kind;
    logic      sym_bit;     // write value, valid with sym_go
    logic      bus_idle;    // selects idle levels while no symbol runs

    // engine to sequencer
    logic      sym_done;    // last cycle of the running symbol
    logic      sym_sample;  // sda seen by the latest read symbol

    modport sequencer (
        output sym_go,
        output sym_kind,
        output sym_bit,
        output bus_idle,
        input  sym_done,
        input  sym_sample
    );

    modport engine (
        input  sym_go,
        input  sym_kind,
        input  sym_bit,
        input  bus_idle,
        output sym_done,
        output sym_sample
    );

endinterface

/* design/i2c_byte_sequencer.sv */
`timescale 1ns/1ps

module i2c_byte_sequencer import i2c_master_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    // host control
    input  logic  i2c_en,
    input  logic  i2c_start,
    input  logic  i2c_stop,
    // write side
    input  byte_t tx_data,
    output logic  tx_done,
    output logic  tx_ready,
    // read side
    output byte_t rx_data,
    output logic  rx_done,
    // symbols to the engine
    i2c_symbol_if.sequencer sym
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HOLD,
        ST_START,
        ST_SEND,
        ST_ACK,
        ST_RECV,
        ST_NACK,
        ST_STOP
    } seq_state_t;

    seq_state_t               state, state_next;
    logic [BIT_CNT_WIDTH-1:0] bit_cnt, bit_cnt_next;
    logic                     addr_phase, addr_phase_next;  // next byte is an address
    logic                     rw_mode, rw_mode_next;        // 1 = read
    logic                     go_next;
    sym_kind_t                kind_next;
    logic                     tx_done_next;
    logic                     tx_ready_next;
    logic                     rx_done_next;
    byte_t                    tx_shift, tx_shift_next;
    byte_t                    rx_shift, rx_shift_next;
    byte_t                    rx_data_next;
    logic                     accept_start;
    logic                     accept_stop;

    // host commands only count while tx_ready is up
    assign accept_start = tx_ready && i2c_start && !i2c_stop;
    assign accept_stop  = tx_ready && i2c_stop && !i2c_start;

    assign sym.sym_bit  = tx_shift[BYTE_BITS-1];  // msb first
    assign sym.bus_idle = (state == ST_IDLE);

    // --------------------
    // next state
    // --------------------
    always_comb begin
        state_next      = state;
        bit_cnt_next    = bit_cnt;
        addr_phase_next = addr_phase;
        rw_mode_next    = rw_mode;
        go_next         = 1'b0;
        kind_next       = sym.sym_kind;
        tx_done_next    = 1'b0;
        tx_ready_next   = 1'b0;
        rx_done_next    = 1'b0;
        tx_shift_next   = tx_shift;
        rx_shift_next   = rx_shift;
        rx_data_next    = rx_data;

        case (state)
            ST_IDLE: begin
                addr_phase_next = 1'b1;  // always start with an address
                if (i2c_en) begin
                    state_next = ST_HOLD;
                end
            end

            ST_HOLD: begin
                tx_ready_next = 1'b1;
                if (accept_start) begin
                    tx_ready_next = 1'b0;
                    tx_shift_next = tx_data;
                    bit_cnt_next  = BIT_CNT_WIDTH'(BYTE_BITS - 1);
                    go_next       = 1'b1;
                    if (addr_phase) begin
                        rw_mode_next = tx_data[0];  // r/w bit of the address
                        kind_next    = SYM_START;
                        state_next   = ST_START;
                    end else begin
                        // data byte goes out without a start
                        kind_next  = SYM_WRITE;
                        state_next = ST_SEND;
                    end
                end else if (accept_stop) begin
                    tx_ready_next = 1'b0;
                    go_next       = 1'b1;
                    kind_next     = SYM_STOP;
                    state_next    = ST_STOP;
                end
            end

            ST_START: begin
                if (sym.sym_done) begin
                    go_next    = 1'b1;
                    kind_next  = SYM_WRITE;
                    state_next = ST_SEND;
                end
            end

            ST_SEND: begin
                if (sym.sym_done) begin
                    go_next       = 1'b1;
                    tx_shift_next = {tx_shift[BYTE_BITS-2:0], 1'b0};
                    if (bit_cnt == '0) begin
                        kind_next  = SYM_READ;  // slave ack slot, never evaluated
                        state_next = ST_ACK;
                    end else begin
                        kind_next    = SYM_WRITE;
                        bit_cnt_next = bit_cnt - 1'b1;
                    end
                end
            end

            ST_ACK: begin
                if (sym.sym_done) begin
                    tx_done_next    = 1'b1;
                    addr_phase_next = 1'b0;
                    if (addr_phase && rw_mode) begin
                        // read address sent, fetch one byte
                        bit_cnt_next = BIT_CNT_WIDTH'(BYTE_BITS - 1);
                        go_next      = 1'b1;
                        kind_next    = SYM_READ;
                        state_next   = ST_RECV;
                    end else begin
                        state_next = ST_HOLD;
                    end
                end
            end

            ST_RECV: begin
                if (sym.sym_done) begin
                    go_next       = 1'b1;
                    rx_shift_next = {rx_shift[BYTE_BITS-2:0], sym.sym_sample};
                    if (bit_cnt == '0) begin
                        kind_next  = SYM_NACK;  // single byte read
                        state_next = ST_NACK;
                    end else begin
                        kind_next    = SYM_READ;
                        bit_cnt_next = bit_cnt - 1'b1;
                    end
                end
            end

            ST_NACK: begin
                if (sym.sym_done) begin
                    rx_data_next    = rx_shift;
                    rx_done_next    = 1'b1;
                    addr_phase_next = 1'b1;  // back to address phase
                    rw_mode_next    = 1'b0;
                    state_next      = ST_HOLD;
                end
            end

            ST_STOP: begin
                if (sym.sym_done) begin
                    state_next = ST_IDLE;
                end
            end

            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // --------------------
    // registers
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= ST_IDLE;
            bit_cnt      <= '0;
            addr_phase   <= 1'b1;
            rw_mode      <= 1'b0;
            sym.sym_go   <= 1'b0;
            sym.sym_kind <= SYM_STOP;
            tx_done      <= 1'b0;
            tx_ready     <= 1'b0;
            rx_done      <= 1'b0;
        end else begin
            state        <= state_next;
            bit_cnt      <= bit_cnt_next;
            addr_phase   <= addr_phase_next;
            rw_mode      <= rw_mode_next;
            sym.sym_go   <= go_next;
            sym.sym_kind <= kind_next;
            tx_done      <= tx_done_next;
            tx_ready     <= tx_ready_next;
            rx_done      <= rx_done_next;
        end
    end

    always_ff @(posedge clk) begin
        tx_shift <= tx_shift_next;
        rx_shift <= rx_shift_next;
        rx_data  <= rx_data_next;
    end

endmodule

/* design/i2c_symbol_engine.sv */
`timescale 1ns/1ps

module i2c_symbol_engine import i2c_master_pkg::*; (
    input  logic clk,
    input  logic reset,
    i2c_symbol_if.engine sym,
    input  logic sda_in,   // sda as seen on the pad
    output logic scl,
    output logic sda_oe,
    output logic sda_out
);

    logic                 busy;
    logic [CNT_WIDTH-1:0] cnt;       // clocks within the quarter
    logic [QTR_WIDTH-1:0] qtr;       // quarter, or half for start/stop
    sym_kind_t            kind_q;
    logic                 bit_q;
    logic                 half_sym;
    logic [CNT_WIDTH-1:0] cnt_last;
    logic [QTR_WIDTH-1:0] qtr_last;
    logic                 cnt_wrap;
    logic                 sample_now;
    logic [2:0]           lvl_next;  // {scl, sda_oe, sda_out}

    // line levels for one quarter of a symbol
    function automatic logic [2:0] sym_levels(
        input sym_kind_t            kind,
        input logic                 bit_val,
        input logic [QTR_WIDTH-1:0] q
    );
        logic       scl_hi;
        logic [2:0] lv;
        scl_hi = (q == QTR_WIDTH'(1)) || (q == QTR_WIDTH'(2));  // low, high, high, low
        case (kind)
            SYM_START: lv = {~q[0], 2'b10};   // sda low, then scl falls
            SYM_STOP:  lv = {1'b1, 1'b1, q[0]};  // sda rises under scl high
            SYM_WRITE: lv = bit_val ? {scl_hi, 2'b00} : {scl_hi, 2'b10};
            SYM_NACK: begin
                if (q == '0) begin
                    lv = {scl_hi, 2'b10};
                end else if (scl_hi) begin
                    lv = {scl_hi, 2'b11};     // driven high while scl is high
                end else begin
                    lv = {scl_hi, 2'b00};
                end
            end
            default:   lv = {scl_hi, 2'b00};  // read, released
        endcase
        return lv;
    endfunction

    assign half_sym = (kind_q == SYM_START) || (kind_q == SYM_STOP);
    assign cnt_last = half_sym ? CNT_WIDTH'(HALF_CYCLES - 1) : CNT_WIDTH'(QUARTER_CYCLES - 1);
    assign qtr_last = half_sym ? QTR_WIDTH'(1) : QTR_WIDTH'(3);
    assign cnt_wrap = (cnt == cnt_last);

    assign sym.sym_done = busy && cnt_wrap && (qtr == qtr_last);

    assign sample_now = busy && (kind_q == SYM_READ) && (qtr == QTR_WIDTH'(1))
                        && (cnt == CNT_WIDTH'(SAMPLE_CYCLE));

    // --------------------
    // quarter timer
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            cnt  <= '0;
            qtr  <= '0;
        end else if (sym.sym_go) begin
            busy <= 1'b1;
            cnt  <= '0;
            qtr  <= '0;
        end else if (busy) begin
            if (cnt_wrap) begin
                cnt <= '0;
                if (qtr == qtr_last) begin
                    busy <= 1'b0;  // symbol ends
                end else begin
                    qtr <= qtr + 1'b1;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // symbol payload and read sample
    always_ff @(posedge clk) begin
        if (sym.sym_go) begin
            kind_q <= sym.sym_kind;
            bit_q  <= sym.sym_bit;
        end
        if (sample_now) begin
            sym.sym_sample <= sda_in;
        end
    end

    // --------------------
    // line levels
    // --------------------
    // the launch cycle already shows the first quarter of the new symbol,
    // so back to back symbols leave no gap on the lines
    always_comb begin
        if (busy) begin
            lvl_next = sym_levels(kind_q, bit_q, qtr);
        end else if (sym.sym_go) begin
            lvl_next = sym_levels(sym.sym_kind, sym.sym_bit, '0);
        end else begin
            lvl_next = {sym.bus_idle, 2'b11};  // sda driven high when parked
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {scl, sda_oe, sda_out} <= 3'b111;  // idle bus
        end else begin
            {scl, sda_oe, sda_out} <= lvl_next;
        end
    end

endmodule

/* design/i2c_master.sv */
`timescale 1ns/1ps

module i2c_master import i2c_master_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    // host control
    input  logic  i2c_en,
    input  logic  i2c_start,
    input  logic  i2c_stop,
    // write side
    input  byte_t tx_data,
    output logic  tx_done,
    output logic  tx_ready,
    // read side
    output byte_t rx_data,
    output logic  rx_done,
    // i2c bus
    output logic  scl,
    inout  tri    sda
);

    logic sda_oe;
    logic sda_out;

    i2c_symbol_if sym_if ();

    // byte level control
    i2c_byte_sequencer u_sequencer (
        .clk       (clk),
        .reset     (reset),
        .i2c_en    (i2c_en),
        .i2c_start (i2c_start),
        .i2c_stop  (i2c_stop),
        .tx_data   (tx_data),
        .tx_done   (tx_done),
        .tx_ready  (tx_ready),
        .rx_data   (rx_data),
        .rx_done   (rx_done),
        .sym       (sym_if.sequencer)
    );

    // symbol timing and line levels
    i2c_symbol_engine u_engine (
        .clk     (clk),
        .reset   (reset),
        .sym     (sym_if.engine),
        .sda_in  (sda),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .sda_out (sda_out)
    );

    assign sda = sda_oe ? sda_out : 1'bz;  // released when not driven

endmodule

/* verification/i2c_slave_model.sv */
`timescale 1ns/1ps

module i2c_slave_model import i2c_master_pkg::*; (
    input  logic  clk,           // oversampling clock
    input  logic  scl,
    inout  wire   sda,
    input  byte_t rd_byte,       // byte returned in the next read
    output logic  byte_strobe,   // one cycle per decoded write byte
    output byte_t byte_val,
    output logic  byte_is_addr,  // byte followed a start
    output int    start_cnt,
    output int    stop_cnt,
    output logic  nack_high      // sda level in the ninth pulse of a read
);

    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_ADDR,
        MODE_WRITE,
        MODE_READ
    } slave_mode_t;

    slave_mode_t mode;
    int          bit_cnt;        // scl pulses within the byte
    byte_t       shift;
    byte_t       rd_shift;
    logic        start_pending;  // sda fell under scl high
    logic        read_req;
    logic        drive_low;
    logic        prev_scl;
    logic        prev_sda;
    logic        scl_now;
    logic        sda_now;

    assign sda = drive_low ? 1'b0 : 1'bz;  // open drain

    initial begin
        mode          = MODE_IDLE;
        bit_cnt       = 0;
        shift         = '0;
        rd_shift      = '0;
        start_pending = 1'b0;
        read_req      = 1'b0;
        prev_scl      = 1'b1;
        prev_sda      = 1'b1;
        drive_low     = 1'b0;
        byte_strobe   = 1'b0;
        byte_val      = '0;
        byte_is_addr  = 1'b0;
        start_cnt     = 0;
        stop_cnt      = 0;
        nack_high     = 1'b0;
    end

    always @(negedge clk) begin
        scl_now = scl;
        sda_now = sda;
        byte_strobe <= 1'b0;
        if (scl_now && prev_sda && !sda_now) begin
            start_pending = 1'b1;  // start or stop, told apart later
        end else if (scl_now && prev_scl && !prev_sda && sda_now) begin
            stop_cnt      <= stop_cnt + 1;
            start_pending = 1'b0;
            mode          = MODE_IDLE;
            bit_cnt       = 0;
            drive_low     <= 1'b0;
        end else if (prev_scl && !scl_now) begin
            if (start_pending) begin
                // scl fell with sda still low
                start_cnt     <= start_cnt + 1;
                start_pending = 1'b0;
                mode          = MODE_ADDR;
                bit_cnt       = 0;
                drive_low     <= 1'b0;
                nack_high     <= 1'b0;
            end else if (mode != MODE_IDLE && bit_cnt == BYTE_BITS) begin
                if (mode == MODE_READ) begin
                    drive_low <= 1'b0;  // nack slot belongs to the master
                end else begin
                    drive_low    <= 1'b1;  // ack
                    byte_strobe  <= 1'b1;
                    byte_val     <= shift;
                    byte_is_addr <= (mode == MODE_ADDR);
                    read_req     = (mode == MODE_ADDR) && shift[0];
                end
            end else if (mode != MODE_IDLE && bit_cnt == BYTE_BITS + 1) begin
                bit_cnt = 0;
                if (mode == MODE_READ) begin
                    mode = MODE_IDLE;
                end else if (mode == MODE_ADDR && read_req) begin
                    mode      = MODE_READ;
                    rd_shift  = rd_byte;
                    drive_low <= !rd_byte[BYTE_BITS-1];  // msb first
                end else begin
                    mode      = MODE_WRITE;
                    drive_low <= 1'b0;
                end
            end else if (mode == MODE_READ && bit_cnt > 0) begin
                drive_low <= !rd_shift[BYTE_BITS-1-bit_cnt];
            end
        end else if (!prev_scl && scl_now && mode != MODE_IDLE) begin
            if (bit_cnt < BYTE_BITS) begin
                shift = {shift[BYTE_BITS-2:0], sda_now};
            end else if (mode == MODE_READ) begin
                nack_high <= sda_now;
            end
            bit_cnt = bit_cnt + 1;
        end
        prev_scl = scl_now;
        prev_sda = sda_now;
    end

endmodule

/* verification/tb_i2c_master.sv */
`timescale 1ns/1ps

module tb_i2c_master import i2c_master_pkg::*; ();

    localparam int CLK_PERIOD    = 40;
    localparam int NUM_TRANS     = 12;
    localparam int MAX_BYTES     = 5;   // budget per transaction
    localparam int SYMS_PER_BYTE = 10;
    localparam int SYM_CYCLES    = 4 * QUARTER_CYCLES;
    localparam int TIMEOUT_NS    = NUM_TRANS * MAX_BYTES * SYMS_PER_BYTE * SYM_CYCLES
                                   * CLK_PERIOD * 2;

    logic  clk = 1'b0;
    logic  reset;
    logic  i2c_en;
    logic  i2c_start;
    logic  i2c_stop;
    byte_t tx_data;
    logic  tx_done;
    logic  tx_ready;
    byte_t rx_data;
    logic  rx_done;
    logic  scl;
    wire   sda;

    byte_t rd_byte;
    logic  byte_strobe;
    byte_t byte_val;
    logic  byte_is_addr;
    int    start_cnt;
    int    stop_cnt;
    logic  nack_high;

    integer            seed;
    logic [31:0]       rnd;
    logic              rw;
    byte_t             addr;
    int                nbytes;
    int                bytes_issued   = 0;
    int                addr_issued    = 0;
    int                reads_issued   = 0;
    int                stops_issued   = 0;
    int                tx_done_cnt    = 0;
    int                rx_done_cnt    = 0;
    int                slave_byte_cnt = 0;
    logic [BYTE_BITS:0] exp_entry;
    logic [BYTE_BITS:0] exp_byte_q[$];  // {start flag, byte}
    byte_t             exp_rd_q[$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    pullup (sda);

    i2c_master DUT (
        .clk       (clk),
        .reset     (reset),
        .i2c_en    (i2c_en),
        .i2c_start (i2c_start),
        .i2c_stop  (i2c_stop),
        .tx_data   (tx_data),
        .tx_done   (tx_done),
        .tx_ready  (tx_ready),
        .rx_data   (rx_data),
        .rx_done   (rx_done),
        .scl       (scl),
        .sda       (sda)
    );

    i2c_slave_model slave (
        .clk          (clk),
        .scl          (scl),
        .sda          (sda),
        .rd_byte      (rd_byte),
        .byte_strobe  (byte_strobe),
        .byte_val     (byte_val),
        .byte_is_addr (byte_is_addr),
        .start_cnt    (start_cnt),
        .stop_cnt     (stop_cnt),
        .nack_high    (nack_high)
    );

    // --------------------
    // failure handling
    // --------------------
    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic fail_with(input string what);
        $display("ERROR at %0d ns: %s", $time, what);
        abort_run();
    endtask

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0d ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    // --------------------
    // monitors
    // --------------------
    always @(negedge clk) begin
        if (tx_done === 1'b1) begin
            tx_done_cnt++;
        end
        if (rx_done === 1'b1) begin
            rx_done_cnt++;
        end
    end

    // slave strobes change on the falling edge
    always @(posedge clk) begin
        if (byte_strobe === 1'b1) begin
            slave_byte_cnt++;
            if (exp_byte_q.size() == 0) begin
                fail_with("the slave decoded a byte that the host never sent");
            end else begin
                exp_entry = exp_byte_q.pop_front();
                check_eq({byte_is_addr, byte_val}, exp_entry, "slave byte {start, data}");
            end
        end
    end

    // --------------------
    // host tasks
    // --------------------
    task automatic wait_ready();
        while (tx_ready !== 1'b1) @(negedge clk);
    endtask

    task automatic enable_bus();
        i2c_en = 1'b1;
        @(negedge clk);
        i2c_en = 1'b0;
        check_eq(tx_ready, 1'b0, "tx_ready one cycle after i2c_en");
        @(negedge clk);
        check_eq(tx_ready, 1'b1, "tx_ready two cycles after i2c_en");
    endtask

    task automatic send_byte(input byte_t value, input logic is_addr);
        wait_ready();
        exp_byte_q.push_back({is_addr, value});
        bytes_issued++;
        if (is_addr) addr_issued++;
        tx_data   = value;
        i2c_start = 1'b1;
        @(negedge clk);
        i2c_start = 1'b0;
        check_eq(tx_ready, 1'b0, "tx_ready after i2c_start");
        while (tx_done !== 1'b1) @(negedge clk);
        @(negedge clk);
        check_eq(tx_done_cnt, bytes_issued, "tx_done pulses");
        check_eq(slave_byte_cnt, bytes_issued, "bytes decoded by the slave");
        check_eq(start_cnt, addr_issued, "start conditions");
    endtask

    task automatic read_byte();
        byte_t exp_val;
        exp_val = exp_rd_q.pop_front();
        reads_issued++;
        while (rx_done !== 1'b1) @(negedge clk);
        check_eq(rx_data, exp_val, "rx_data at rx_done");
        check_eq(nack_high, 1'b1, "sda in the master nack pulse");
        @(negedge clk);
        check_eq(rx_done_cnt, reads_issued, "rx_done pulses");
    endtask

    task automatic send_stop();
        int idle_cycles;
        wait_ready();
        stops_issued++;
        i2c_stop = 1'b1;
        @(negedge clk);
        i2c_stop = 1'b0;
        check_eq(tx_ready, 1'b0, "tx_ready after i2c_stop");
        while (stop_cnt != stops_issued) @(negedge clk);
        rnd         = $random(seed);
        idle_cycles = HALF_CYCLES + 100 + (rnd[7:0] % 200);  // outlasts the stop symbol
        repeat (idle_cycles) begin
            @(negedge clk);
            check_eq(scl, 1'b1, "scl after stop");
            check_eq(tx_ready, 1'b0, "tx_ready after stop");
        end
        check_eq(sda, 1'b1, "sda on the idle bus");
    endtask

    // --------------------
    // stimulus
    // --------------------
    initial begin
        seed      = 32'h4e7a;
        reset     = 1'b1;
        i2c_en    = 1'b0;
        i2c_start = 1'b0;
        i2c_stop  = 1'b0;
        tx_data   = '0;
        rd_byte   = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_eq(scl, 1'b1, "scl after reset");
        check_eq(sda, 1'b1, "sda after reset");
        check_eq(tx_done, 1'b0, "tx_done after reset");
        check_eq(tx_ready, 1'b0, "tx_ready after reset");
        check_eq(rx_done, 1'b0, "rx_done after reset");

        for (int t = 0; t < NUM_TRANS; t++) begin
            enable_bus();
            rnd    = $random(seed);
            rw     = rnd[0];
            nbytes = 1 + (rnd[15:8] % 3);
            addr   = {rnd[23:17], rw};
            if (rw) begin
                // each read byte needs its own address
                for (int i = 0; i < nbytes; i++) begin
                    rnd     = $random(seed);
                    rd_byte = rnd[7:0];
                    exp_rd_q.push_back(rnd[7:0]);
                    send_byte(addr, 1'b1);
                    read_byte();
                end
            end else begin
                send_byte(addr, 1'b1);
                for (int i = 0; i < nbytes; i++) begin
                    rnd = $random(seed);
                    send_byte(rnd[7:0], 1'b0);
                end
            end
            send_stop();
        end

        check_eq(tx_done_cnt, bytes_issued, "tx_done pulses at the end");
        check_eq(rx_done_cnt, reads_issued, "rx_done pulses at the end");
        check_eq(stop_cnt, stops_issued, "stop conditions at the end");
        $display("Regression passed");
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the transfers were still running after %0d ns", TIMEOUT_NS);
        abort_run();
    end

endmodule

/* filelist.f */
design/i2c_master_pkg.sv
design/i2c_symbol_if.sv
design/i2c_byte_sequencer.sv
design/i2c_symbol_engine.sv
design/i2c_master.sv
verification/i2c_slave_model.sv
verification/tb_i2c_master.sv

/* Bender.yml */
package:
  name: i2c_master

sources:
  - design/i2c_master_pkg.sv
  - design/i2c_symbol_if.sv
  - design/i2c_byte_sequencer.sv
  - design/i2c_symbol_engine.sv
  - design/i2c_master.sv
  - target: simulation
    files:
      - verification/i2c_slave_model.sv
      - verification/tb_i2c_master.sv
